/* src/renamePkg.sv */
package renamePkg;

  // --------------------
  // logical side
  // --------------------

  localparam int NumLogRegs = 32;  // one map table entry per logical register
  localparam int LogRegW = $clog2(NumLogRegs);  // index width for a logical register

  // --------------------
  // physical side
  // --------------------

  localparam int NumPhysRegs = 64;  // size of the physical register file
  localparam int PhysRegW = $clog2(NumPhysRegs);  // index width for a physical register

  // --------------------
  // commit and recovery
  // --------------------

  // the same width bounds both the retire group and the recovery group,
  // since the speculative map on the other side has only four write ports
  localparam int CommitWidth = 4;  // retiring slots presented per cycle

  // a full walk over the table in groups of CommitWidth entries
  localparam int RecoverSteps = NumLogRegs / CommitWidth;  // cycles of one walk

endpackage

/* src/archMapRam.sv */
`timescale 1ns/1ps

module archMapRam (
  input  logic                          clk,
  input  logic                          reset,
  // read side is shared by commit lookups and the recovery walk
  input  logic [renamePkg::LogRegW-1:0]  rdAddr0_i,
  input  logic [renamePkg::LogRegW-1:0]  rdAddr1_i,
  input  logic [renamePkg::LogRegW-1:0]  rdAddr2_i,
  input  logic [renamePkg::LogRegW-1:0]  rdAddr3_i,
  output logic [renamePkg::PhysRegW-1:0] rdData0_o,
  output logic [renamePkg::PhysRegW-1:0] rdData1_o,
  output logic [renamePkg::PhysRegW-1:0] rdData2_o,
  output logic [renamePkg::PhysRegW-1:0] rdData3_o,
  // write side carries the surviving commits of a group
  input  logic                          wrEn0_i,
  input  logic                          wrEn1_i,
  input  logic                          wrEn2_i,
  input  logic                          wrEn3_i,
  input  logic [renamePkg::LogRegW-1:0]  wrAddr0_i,
  input  logic [renamePkg::LogRegW-1:0]  wrAddr1_i,
  input  logic [renamePkg::LogRegW-1:0]  wrAddr2_i,
  input  logic [renamePkg::LogRegW-1:0]  wrAddr3_i,
  input  logic [renamePkg::PhysRegW-1:0] wrData0_i,
  input  logic [renamePkg::PhysRegW-1:0] wrData1_i,
  input  logic [renamePkg::PhysRegW-1:0] wrData2_i,
  input  logic [renamePkg::PhysRegW-1:0] wrData3_i
);

  import renamePkg::*;

  logic [PhysRegW-1:0] mapTable [NumLogRegs];  // committed logical to physical mapping

  // --------------------
  // write ports
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumLogRegs; i++) begin
        mapTable[i] <= PhysRegW'(i);  // identity map gives each logical reg its own phys reg
      end
    end else begin
      // later statements win, so port 3 has the last word on a shared address
      if (wrEn0_i) begin
        mapTable[wrAddr0_i] <= wrData0_i;  // oldest slot
      end
      if (wrEn1_i) begin
        mapTable[wrAddr1_i] <= wrData1_i;
      end
      if (wrEn2_i) begin
        mapTable[wrAddr2_i] <= wrData2_i;
      end
      if (wrEn3_i) begin
        mapTable[wrAddr3_i] <= wrData3_i;  // youngest slot
      end
    end
  end

  // --------------------
  // read ports
  // --------------------

  // asynchronous reads see the table as it stood before this edge's writes
  assign rdData0_o = mapTable[rdAddr0_i];  // slot 0 or walk entry base+0
  assign rdData1_o = mapTable[rdAddr1_i];  // slot 1 or walk entry base+1
  assign rdData2_o = mapTable[rdAddr2_i];  // slot 2 or walk entry base+2
  assign rdData3_o = mapTable[rdAddr3_i];  // slot 3 or walk entry base+3

endmodule

/* src/commitCoalescer.sv */
`timescale 1ns/1ps

module commitCoalescer (
  // commit group from the retire stage, slot 0 is the oldest
  input  logic                          commitValid0_i,
  input  logic                          commitValid1_i,
  input  logic                          commitValid2_i,
  input  logic                          commitValid3_i,
  input  logic [renamePkg::LogRegW-1:0]  commitLog0_i,
  input  logic [renamePkg::LogRegW-1:0]  commitLog1_i,
  input  logic [renamePkg::LogRegW-1:0]  commitLog2_i,
  input  logic [renamePkg::LogRegW-1:0]  commitLog3_i,
  input  logic [renamePkg::PhysRegW-1:0] commitPhys0_i,
  input  logic [renamePkg::PhysRegW-1:0] commitPhys1_i,
  input  logic [renamePkg::PhysRegW-1:0] commitPhys2_i,
  input  logic [renamePkg::PhysRegW-1:0] commitPhys3_i,
  // walk control
  input  logic                          walkActive_i,
  input  logic [renamePkg::LogRegW-1:0]  walkBase_i,
  // map table interface
  input  logic [renamePkg::PhysRegW-1:0] rdData0_i,
  input  logic [renamePkg::PhysRegW-1:0] rdData1_i,
  input  logic [renamePkg::PhysRegW-1:0] rdData2_i,
  input  logic [renamePkg::PhysRegW-1:0] rdData3_i,
  output logic [renamePkg::LogRegW-1:0]  rdAddr0_o,
  output logic [renamePkg::LogRegW-1:0]  rdAddr1_o,
  output logic [renamePkg::LogRegW-1:0]  rdAddr2_o,
  output logic [renamePkg::LogRegW-1:0]  rdAddr3_o,
  output logic                          wrEn0_o,
  output logic                          wrEn1_o,
  output logic                          wrEn2_o,
  output logic                          wrEn3_o,
  output logic [renamePkg::LogRegW-1:0]  wrAddr0_o,
  output logic [renamePkg::LogRegW-1:0]  wrAddr1_o,
  output logic [renamePkg::LogRegW-1:0]  wrAddr2_o,
  output logic [renamePkg::LogRegW-1:0]  wrAddr3_o,
  output logic [renamePkg::PhysRegW-1:0] wrData0_o,
  output logic [renamePkg::PhysRegW-1:0] wrData1_o,
  output logic [renamePkg::PhysRegW-1:0] wrData2_o,
  output logic [renamePkg::PhysRegW-1:0] wrData3_o,
  // release toward the free list and logical half of the recovery pairs
  output logic [renamePkg::PhysRegW-1:0] releasedPhys0_o,
  output logic [renamePkg::PhysRegW-1:0] releasedPhys1_o,
  output logic [renamePkg::PhysRegW-1:0] releasedPhys2_o,
  output logic [renamePkg::PhysRegW-1:0] releasedPhys3_o,
  output logic [renamePkg::LogRegW-1:0]  recoverLog0_o,
  output logic [renamePkg::LogRegW-1:0]  recoverLog1_o,
  output logic [renamePkg::LogRegW-1:0]  recoverLog2_o,
  output logic [renamePkg::LogRegW-1:0]  recoverLog3_o
);

  import renamePkg::*;

  logic [CommitWidth-1:0] valid;                    // slot strobes gathered by index
  logic [CommitWidth-1:0] overridden;               // a younger valid slot hits the same dest
  logic [CommitWidth-1:0] writeEn;                  // slot survives coalescing and may write
  logic [LogRegW-1:0]     dest        [CommitWidth]; // logical destination per slot
  logic [PhysRegW-1:0]    newPhys     [CommitWidth]; // freshly allocated phys reg per slot
  logic [PhysRegW-1:0]    oldPhys     [CommitWidth]; // current table content at the read address
  logic [LogRegW-1:0]     walkAddr    [CommitWidth]; // recovery index base+n
  logic [LogRegW-1:0]     readAddr    [CommitWidth]; // address sent to the table
  logic [PhysRegW-1:0]    releasePhys [CommitWidth]; // register freed by each slot

  // --------------------
  // gather slots
  // --------------------

  assign valid      = {commitValid3_i, commitValid2_i, commitValid1_i, commitValid0_i};
  assign dest[0]    = commitLog0_i;
  assign dest[1]    = commitLog1_i;
  assign dest[2]    = commitLog2_i;
  assign dest[3]    = commitLog3_i;
  assign newPhys[0] = commitPhys0_i;
  assign newPhys[1] = commitPhys1_i;
  assign newPhys[2] = commitPhys2_i;
  assign newPhys[3] = commitPhys3_i;
  assign oldPhys[0] = rdData0_i;
  assign oldPhys[1] = rdData1_i;
  assign oldPhys[2] = rdData2_i;
  assign oldPhys[3] = rdData3_i;

  // --------------------
  // coalescing
  // --------------------

  always_comb begin
    for (int i = 0; i < CommitWidth; i++) begin
      overridden[i] = 1'b0;  // the youngest slot never finds anyone after it
      for (int j = i + 1; j < CommitWidth; j++) begin
        if (valid[j] && (dest[j] == dest[i])) begin
          overridden[i] = 1'b1;  // a younger commit owns this logical reg
        end
      end
      writeEn[i]     = valid[i] & ~overridden[i] & ~walkActive_i;  // table frozen during a walk
      walkAddr[i]    = walkBase_i + LogRegW'(i);  // four consecutive entries per walk cycle
      readAddr[i]    = walkActive_i ? walkAddr[i] : dest[i];
      // an overridden mapping dies at once, otherwise the replaced one is freed
      releasePhys[i] = overridden[i] ? newPhys[i] : oldPhys[i];
    end
  end

  // --------------------
  // outputs
  // --------------------

  assign rdAddr0_o       = readAddr[0];
  assign rdAddr1_o       = readAddr[1];
  assign rdAddr2_o       = readAddr[2];
  assign rdAddr3_o       = readAddr[3];
  assign wrEn0_o         = writeEn[0];
  assign wrEn1_o         = writeEn[1];
  assign wrEn2_o         = writeEn[2];
  assign wrEn3_o         = writeEn[3];
  assign wrAddr0_o       = dest[0];  // write address is always the commit destination
  assign wrAddr1_o       = dest[1];
  assign wrAddr2_o       = dest[2];
  assign wrAddr3_o       = dest[3];
  assign wrData0_o       = newPhys[0];
  assign wrData1_o       = newPhys[1];
  assign wrData2_o       = newPhys[2];
  assign wrData3_o       = newPhys[3];
  assign releasedPhys0_o = releasePhys[0];
  assign releasedPhys1_o = releasePhys[1];
  assign releasedPhys2_o = releasePhys[2];
  assign releasedPhys3_o = releasePhys[3];
  assign recoverLog0_o   = walkAddr[0];
  assign recoverLog1_o   = walkAddr[1];
  assign recoverLog2_o   = walkAddr[2];
  assign recoverLog3_o   = walkAddr[3];

endmodule

/* src/recoveryCounter.sv */
`timescale 1ns/1ps

module recoveryCounter (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         clear_i,     // restart the walk at entry 0
  input  logic                         step_i,      // advance to the next group
  output logic [renamePkg::LogRegW-1:0] walkBase_o,  // first logical index of the current group
  output logic                         lastGroup_o  // current group holds the final entries
);

  import renamePkg::*;

  logic [LogRegW-1:0] baseQ;  // walk position in units of logical entries

  always_ff @(posedge clk) begin
    if (reset) begin
      baseQ <= '0;
    end else if (clear_i) begin
      baseQ <= '0;  // clear has priority over step
    end else if (step_i) begin
      baseQ <= baseQ + LogRegW'(CommitWidth);  // wraps back to zero after the final group
    end
  end

  assign walkBase_o = baseQ;

  // the only place that knows where the table ends
  assign lastGroup_o = (baseQ == LogRegW'(NumLogRegs - CommitWidth));

endmodule

/* src/recoverySequencer.sv */
`timescale 1ns/1ps

module recoverySequencer (
  input  logic clk,
  input  logic reset,
  input  logic recoverFlag_i,   // single-cycle request after exception or mispredict
  input  logic lastGroup_i,     // counter sits on the final group
  output logic walkActive_o,    // a walk is in progress this cycle
  output logic counterClear_o,  // restart the base index
  output logic counterStep_o,   // advance the base index
  output logic recoverDone_o    // final group goes out this cycle
);

  typedef enum logic {
    Idle,
    Walking
  } seqState_t;

  seqState_t stateQ;  // current state
  seqState_t stateD;  // next state

  // --------------------
  // state register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      stateQ <= Idle;
    end else begin
      stateQ <= stateD;
    end
  end

  // --------------------
  // next state
  // --------------------

  always_comb begin
    stateD         = stateQ;
    counterClear_o = 1'b0;
    counterStep_o  = 1'b0;
    recoverDone_o  = 1'b0;
    case (stateQ)
      Idle: begin
        if (recoverFlag_i) begin
          counterClear_o = 1'b1;  // base reads 0 in the first walk cycle
          stateD         = Walking;
        end
      end
      Walking: begin
        counterStep_o = 1'b1;  // one group per cycle with no stalls
        // recoverFlag_i is not looked at here so a repeat request is dropped
        if (lastGroup_i) begin
          recoverDone_o = 1'b1;
          stateD        = Idle;  // commits resume in the cycle after done
        end
      end
      default: begin
        stateD = Idle;
      end
    endcase
  end

  assign walkActive_o = (stateQ == Walking);

endmodule

/* src/archRenameCommit.sv */
`timescale 1ns/1ps

module archRenameCommit (
  input  logic                          clk,
  input  logic                          reset,
  // retiring instructions, slot 0 oldest
  input  logic                          commitValid0_i,
  input  logic                          commitValid1_i,
  input  logic                          commitValid2_i,
  input  logic                          commitValid3_i,
  input  logic [renamePkg::LogRegW-1:0]  commitLog0_i,
  input  logic [renamePkg::LogRegW-1:0]  commitLog1_i,
  input  logic [renamePkg::LogRegW-1:0]  commitLog2_i,
  input  logic [renamePkg::LogRegW-1:0]  commitLog3_i,
  input  logic [renamePkg::PhysRegW-1:0] commitPhys0_i,
  input  logic [renamePkg::PhysRegW-1:0] commitPhys1_i,
  input  logic [renamePkg::PhysRegW-1:0] commitPhys2_i,
  input  logic [renamePkg::PhysRegW-1:0] commitPhys3_i,
  input  logic                          recoverFlag_i,
  // registers returned to the free list
  output logic                          releasedValid0_o,
  output logic                          releasedValid1_o,
  output logic                          releasedValid2_o,
  output logic                          releasedValid3_o,
  output logic [renamePkg::PhysRegW-1:0] releasedPhys0_o,
  output logic [renamePkg::PhysRegW-1:0] releasedPhys1_o,
  output logic [renamePkg::PhysRegW-1:0] releasedPhys2_o,
  output logic [renamePkg::PhysRegW-1:0] releasedPhys3_o,
  // pairs for the speculative rename map
  output logic                          recoverValid_o,
  output logic [renamePkg::LogRegW-1:0]  recoverLog0_o,
  output logic [renamePkg::LogRegW-1:0]  recoverLog1_o,
  output logic [renamePkg::LogRegW-1:0]  recoverLog2_o,
  output logic [renamePkg::LogRegW-1:0]  recoverLog3_o,
  output logic [renamePkg::PhysRegW-1:0] recoverPhys0_o,
  output logic [renamePkg::PhysRegW-1:0] recoverPhys1_o,
  output logic [renamePkg::PhysRegW-1:0] recoverPhys2_o,
  output logic [renamePkg::PhysRegW-1:0] recoverPhys3_o,
  output logic                          recoverDone_o
);

  import renamePkg::*;

  logic                walkActive;                          // sequencer is walking the table
  logic                counterClear;                        // restart the walk index
  logic                counterStep;                         // advance the walk index
  logic                lastGroup;                           // walk index at the final group
  logic [LogRegW-1:0]  walkBase;                            // first entry of this walk group
  logic [LogRegW-1:0]  rdAddr0, rdAddr1, rdAddr2, rdAddr3;  // table read addresses
  logic [PhysRegW-1:0] rdData0, rdData1, rdData2, rdData3;  // table read data
  logic                wrEn0, wrEn1, wrEn2, wrEn3;          // surviving commit writes
  logic [LogRegW-1:0]  wrAddr0, wrAddr1, wrAddr2, wrAddr3;  // commit destinations
  logic [PhysRegW-1:0] wrData0, wrData1, wrData2, wrData3;  // new mappings

  // --------------------
  // map storage
  // --------------------

  archMapRam mapRam (
    .clk(clk), .reset(reset),
    .rdAddr0_i(rdAddr0), .rdAddr1_i(rdAddr1), .rdAddr2_i(rdAddr2), .rdAddr3_i(rdAddr3),
    .rdData0_o(rdData0), .rdData1_o(rdData1), .rdData2_o(rdData2), .rdData3_o(rdData3),
    .wrEn0_i(wrEn0), .wrEn1_i(wrEn1), .wrEn2_i(wrEn2), .wrEn3_i(wrEn3),
    .wrAddr0_i(wrAddr0), .wrAddr1_i(wrAddr1), .wrAddr2_i(wrAddr2), .wrAddr3_i(wrAddr3),
    .wrData0_i(wrData0), .wrData1_i(wrData1), .wrData2_i(wrData2), .wrData3_i(wrData3)
  );

  // --------------------
  // commit coalescing
  // --------------------

  commitCoalescer coalescer (
    .commitValid0_i(commitValid0_i), .commitValid1_i(commitValid1_i),
    .commitValid2_i(commitValid2_i), .commitValid3_i(commitValid3_i),
    .commitLog0_i(commitLog0_i), .commitLog1_i(commitLog1_i),
    .commitLog2_i(commitLog2_i), .commitLog3_i(commitLog3_i),
    .commitPhys0_i(commitPhys0_i), .commitPhys1_i(commitPhys1_i),
    .commitPhys2_i(commitPhys2_i), .commitPhys3_i(commitPhys3_i),
    .walkActive_i(walkActive), .walkBase_i(walkBase),
    .rdData0_i(rdData0), .rdData1_i(rdData1), .rdData2_i(rdData2), .rdData3_i(rdData3),
    .rdAddr0_o(rdAddr0), .rdAddr1_o(rdAddr1), .rdAddr2_o(rdAddr2), .rdAddr3_o(rdAddr3),
    .wrEn0_o(wrEn0), .wrEn1_o(wrEn1), .wrEn2_o(wrEn2), .wrEn3_o(wrEn3),
    .wrAddr0_o(wrAddr0), .wrAddr1_o(wrAddr1), .wrAddr2_o(wrAddr2), .wrAddr3_o(wrAddr3),
    .wrData0_o(wrData0), .wrData1_o(wrData1), .wrData2_o(wrData2), .wrData3_o(wrData3),
    .releasedPhys0_o(releasedPhys0_o), .releasedPhys1_o(releasedPhys1_o),
    .releasedPhys2_o(releasedPhys2_o), .releasedPhys3_o(releasedPhys3_o),
    .recoverLog0_o(recoverLog0_o), .recoverLog1_o(recoverLog1_o),
    .recoverLog2_o(recoverLog2_o), .recoverLog3_o(recoverLog3_o)
  );

  // --------------------
  // recovery walk
  // --------------------

  recoveryCounter counter (
    .clk(clk), .reset(reset),
    .clear_i(counterClear), .step_i(counterStep),
    .walkBase_o(walkBase), .lastGroup_o(lastGroup)
  );

  recoverySequencer sequencer (
    .clk(clk), .reset(reset),
    .recoverFlag_i(recoverFlag_i), .lastGroup_i(lastGroup),
    .walkActive_o(walkActive), .counterClear_o(counterClear),
    .counterStep_o(counterStep), .recoverDone_o(recoverDone_o)
  );

  // the active list is stalled during a walk so its commits release nothing
  assign releasedValid0_o = commitValid0_i & ~walkActive;
  assign releasedValid1_o = commitValid1_i & ~walkActive;
  assign releasedValid2_o = commitValid2_i & ~walkActive;
  assign releasedValid3_o = commitValid3_i & ~walkActive;

  assign recoverValid_o = walkActive;  // one group of pairs in every walk cycle
  assign recoverPhys0_o = rdData0;     // read port n holds entry base+n while walking
  assign recoverPhys1_o = rdData1;
  assign recoverPhys2_o = rdData2;
  assign recoverPhys3_o = rdData3;

endmodule

/* bench/archRenameCommitTb.sv */
`timescale 1ns/1ps

module archRenameCommitTb;

  import renamePkg::*;

  // --------------------
  // run length
  // --------------------

  localparam int ClkPeriod   = 8;    // ns per cycle
  localparam int ResetCycles = 10;   // reset held for this many edges
  localparam int IdleCycles  = 3;    // quiet cycles checked right after reset
  localparam int NumDistinct = 200;  // groups whose destinations never collide
  localparam int NumPool     = 200;  // groups drawn from three destinations so they collide
  localparam int NumMid      = 50;   // mixed groups between the last two walks
  localparam int NumWalks    = 4;    // every walk costs a request cycle, the walk and one idle
  localparam int WatchdogCycles = ResetCycles + IdleCycles + NumDistinct + NumPool + NumMid
                                  + NumWalks * (RecoverSteps + 2) + 100;

  logic clk = 1'b0;
  logic reset;
  logic recoverFlag;
  logic                cValid [CommitWidth];  // commit strobes toward the DUT
  logic [LogRegW-1:0]  cLog   [CommitWidth];
  logic [PhysRegW-1:0] cPhys  [CommitWidth];
  wire                 rValid [CommitWidth];  // release strobes from the DUT
  wire [PhysRegW-1:0]  rPhys  [CommitWidth];
  wire [LogRegW-1:0]   recLog  [CommitWidth];  // recovery pairs from the DUT
  wire [PhysRegW-1:0]  recPhys [CommitWidth];
  wire                 recoverValid;
  wire                 recoverDone;

  logic [PhysRegW-1:0] model   [NumLogRegs];   // expected committed map
  logic                grpValid [CommitWidth];  // next group to drive
  logic [LogRegW-1:0]  grpLog   [CommitWidth];
  logic [PhysRegW-1:0] grpPhys  [CommitWidth];
  int                  seedDummy;

  always #(ClkPeriod / 2) clk = ~clk;  // 8 ns period

  archRenameCommit u_dut (
    .clk(clk), .reset(reset), .recoverFlag_i(recoverFlag),
    .commitValid0_i(cValid[0]), .commitValid1_i(cValid[1]),
    .commitValid2_i(cValid[2]), .commitValid3_i(cValid[3]),
    .commitLog0_i(cLog[0]), .commitLog1_i(cLog[1]), .commitLog2_i(cLog[2]), .commitLog3_i(cLog[3]),
    .commitPhys0_i(cPhys[0]), .commitPhys1_i(cPhys[1]),
    .commitPhys2_i(cPhys[2]), .commitPhys3_i(cPhys[3]),
    .releasedValid0_o(rValid[0]), .releasedValid1_o(rValid[1]),
    .releasedValid2_o(rValid[2]), .releasedValid3_o(rValid[3]),
    .releasedPhys0_o(rPhys[0]), .releasedPhys1_o(rPhys[1]),
    .releasedPhys2_o(rPhys[2]), .releasedPhys3_o(rPhys[3]),
    .recoverValid_o(recoverValid), .recoverDone_o(recoverDone),
    .recoverLog0_o(recLog[0]), .recoverLog1_o(recLog[1]),
    .recoverLog2_o(recLog[2]), .recoverLog3_o(recLog[3]),
    .recoverPhys0_o(recPhys[0]), .recoverPhys1_o(recPhys[1]),
    .recoverPhys2_o(recPhys[2]), .recoverPhys3_o(recPhys[3])
  );

  // --------------------
  // compare tasks
  // --------------------

  task automatic checkPhys(input string name, input logic [PhysRegW-1:0] expVal,
                           input logic [PhysRegW-1:0] actVal);
    if (actVal !== expVal) begin
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expVal, actVal);
      $display("Verification failed");
      $fatal(1, "physical register mismatch on %s", name);
    end
  endtask

  task automatic checkLog(input string name, input logic [LogRegW-1:0] expVal,
                          input logic [LogRegW-1:0] actVal);
    if (actVal !== expVal) begin
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expVal, actVal);
      $display("Verification failed");
      $fatal(1, "logical index mismatch on %s", name);
    end
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("[FAIL] %0t %s expected %0b actual %0b", $time, name, expVal, actVal);
      $display("Verification failed");
      $fatal(1, "strobe mismatch on %s", name);
    end
  endtask

  // --------------------
  // stimulus
  // --------------------

  task automatic randGroup(input bit pooled);
    int  off;
    logic clash;
    off = int'($urandom % 11);  // pool is off, off+7 and off+14
    for (int i = 0; i < CommitWidth; i++) begin
      grpValid[i] = ($urandom % 4) != 0;  // roughly one slot in four has no destination
      grpPhys[i]  = PhysRegW'($urandom % NumPhysRegs);
      if (pooled) begin
        grpLog[i] = LogRegW'(off + 7 * int'($urandom % 3));
      end else begin
        clash = 1'b1;
        while (clash) begin
          grpLog[i] = LogRegW'($urandom % NumLogRegs);
          clash = 1'b0;
          for (int j = 0; j < i; j++) begin
            if (grpLog[j] == grpLog[i]) clash = 1'b1;  // redraw until unique in the group
          end
        end
      end
    end
  endtask

  task automatic driveGroup();
    for (int i = 0; i < CommitWidth; i++) begin
      cValid[i] <= grpValid[i];
      cLog[i]   <= grpLog[i];
      cPhys[i]  <= grpPhys[i];
    end
  endtask

  // one commit cycle, checked at the falling edge while the release path is settled
  task automatic commitStep(input bit pooled);
    logic over [CommitWidth];
    logic [PhysRegW-1:0] expRel;
    randGroup(pooled);
    @(posedge clk);
    driveGroup();
    @(negedge clk);
    checkBit("recoverValid_o", 1'b0, recoverValid);
    checkBit("recoverDone_o", 1'b0, recoverDone);
    for (int i = 0; i < CommitWidth; i++) begin
      over[i] = 1'b0;
      for (int j = i + 1; j < CommitWidth; j++) begin
        if (grpValid[j] && grpLog[j] == grpLog[i]) over[i] = 1'b1;  // younger slot wins
      end
      checkBit($sformatf("releasedValid%0d_o", i), grpValid[i], rValid[i]);
      if (grpValid[i]) begin
        expRel = over[i] ? grpPhys[i] : model[grpLog[i]];  // dead new reg or the replaced one
        checkPhys($sformatf("releasedPhys%0d_o", i), expRel, rPhys[i]);
      end
    end
    for (int i = 0; i < CommitWidth; i++) begin
      if (grpValid[i] && !over[i]) model[grpLog[i]] = grpPhys[i];  // takes effect at the edge
    end
  endtask

  // request a walk and follow it group by group, with noise adding commits and a second request
  task automatic runWalk(input bit noise);
    int idx;
    for (int i = 0; i < CommitWidth; i++) grpValid[i] = 1'b0;
    @(posedge clk);
    recoverFlag <= 1'b1;
    driveGroup();
    @(negedge clk);
    checkBit("recoverValid_o", 1'b0, recoverValid);  // flag not sampled yet
    for (int s = 0; s < RecoverSteps; s++) begin
      @(posedge clk);
      recoverFlag <= noise && (s == 3);  // repeat request in the middle of the walk
      if (noise) begin
        randGroup(s[0]);
      end else begin
        for (int i = 0; i < CommitWidth; i++) grpValid[i] = 1'b0;
      end
      driveGroup();
      @(negedge clk);
      checkBit("recoverValid_o", 1'b1, recoverValid);
      checkBit("recoverDone_o", s == RecoverSteps - 1, recoverDone);
      for (int n = 0; n < CommitWidth; n++) begin
        idx = s * CommitWidth + n;  // entries go out in ascending order
        checkLog($sformatf("recoverLog%0d_o", n), LogRegW'(idx), recLog[n]);
        checkPhys($sformatf("recoverPhys%0d_o", n), model[idx], recPhys[n]);
        checkBit($sformatf("releasedValid%0d_o", n), 1'b0, rValid[n]);
      end
    end
    @(posedge clk);
    recoverFlag <= 1'b0;
    for (int i = 0; i < CommitWidth; i++) grpValid[i] = 1'b0;
    driveGroup();
    @(negedge clk);
    checkBit("recoverValid_o", 1'b0, recoverValid);  // walk length did not change
    checkBit("recoverDone_o", 1'b0, recoverDone);
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    seedDummy   = $urandom(29367);
    reset       <= 1'b1;
    recoverFlag <= 1'b0;
    for (int i = 0; i < CommitWidth; i++) begin
      cValid[i]   <= 1'b0;
      cLog[i]     <= '0;
      cPhys[i]    <= '0;
      grpValid[i] = 1'b0;
      grpLog[i]   = '0;
      grpPhys[i]  = '0;
    end
    for (int i = 0; i < NumLogRegs; i++) model[i] = PhysRegW'(i);  // identity after reset
    repeat (ResetCycles) @(posedge clk);
    reset <= 1'b0;
    repeat (IdleCycles) begin
      @(negedge clk);
      checkBit("recoverValid_o", 1'b0, recoverValid);
      checkBit("recoverDone_o", 1'b0, recoverDone);
      for (int i = 0; i < CommitWidth; i++) begin
        checkBit($sformatf("releasedValid%0d_o", i), 1'b0, rValid[i]);
      end
    end
    runWalk(1'b0);                                 // identity map comes back
    repeat (NumDistinct) commitStep(1'b0);
    repeat (NumPool) commitStep(1'b1);
    runWalk(1'b0);
    runWalk(1'b1);                                 // commits and request during the walk are ignored
    for (int k = 0; k < NumMid; k++) commitStep(k[0]);
    runWalk(1'b0);                                 // later commits show up in the walk
    $display("Verification passed");
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("timeout: the run did not end within %0d cycles", WatchdogCycles);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* filelist.f */
src/renamePkg.sv
src/archMapRam.sv
src/commitCoalescer.sv
src/recoveryCounter.sv
src/recoverySequencer.sv
src/archRenameCommit.sv
bench/archRenameCommitTb.sv

/* run.sh */
#!/bin/sh
# Build and run the archRenameCommit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  -f filelist.f \
  --top-module archRenameCommitTb \
  -Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0
